/* verilog/sd_pkg.sv */
/*
 * Sigma-delta demodulator shared definitions.
 * Holds the modulator clock divider, the decimation ratio, the sinc3
 * filter width and the vector types used across the data path.
 */
package sd_pkg;

    // System clock cycles per half period of the modulator clock
    localparam int CLOCK_DIV = 2;

    // Modulator bits that make up one output sample
    localparam int DECIMATION = 128;

    // Width of the bit counter inside one decimation period
    localparam int DEC_LOG2 = 7;

    // Filter order, which sets the number of integrators and comb stages
    localparam int CIC_ORDER = 3;

    // Filter word width
    // The CIC growth is DEC_LOG2 * CIC_ORDER = 21 bits plus sign, so 24 bits leave headroom
    localparam int SAMPLE_W = 24;

    // Steady output for an all-ones stream, DECIMATION to the power CIC_ORDER
    localparam int FULL_SCALE = 2 ** (DEC_LOG2 * CIC_ORDER);

    // Signed word for integrators, comb stages and output samples
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // Counts modulator bits inside one decimation period
    typedef logic [DEC_LOG2-1:0] dec_count_t;

    // Counts system cycles inside one half period of the modulator clock
    typedef logic [1:0] div_count_t;

endpackage

/* verilog/sd_clock_gen.sv */
/*
 * Modulator clock generator.
 * Divides the system clock into the clock sent to the external modulators
 * and produces the per-bit and per-sample strobes for the filters.
 */
`timescale 1ns/1ps

module sd_clock_gen (
    input  logic clock,
    input  logic rst_n,
    output logic clock_out,
    output logic bit_strobe,
    output logic dec_strobe
);

    // Position inside the current half period of clock_out
    sd_pkg::div_count_t div_count;

    // Position inside the current decimation period, counted in modulator bits
    sd_pkg::dec_count_t dec_count;

    // High in the last system cycle of a half period, when clock_out toggles
    logic half_done;

    // True when the pending toggle takes clock_out from low to high
    logic rising;

    // True when the bit about to be taken is the last one of its window
    logic last_bit;

    assign half_done = (div_count == sd_pkg::div_count_t'(sd_pkg::CLOCK_DIV - 1));
    assign rising    = half_done && !clock_out;
    assign last_bit  = (dec_count == sd_pkg::dec_count_t'(sd_pkg::DECIMATION - 1));

    // Half period counter and the modulator clock itself
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            div_count <= '0;
            clock_out <= 1'b0;
        end else if (half_done) begin
            div_count <= '0;
            clock_out <= ~clock_out;
        end else begin
            div_count <= div_count + 1'b1;
        end
    end

    // The bit strobe is registered with the low to high toggle,
    // so it is high exactly in the first cycle that clock_out is high
    // The modulators launch their bit on that edge, and by then the previous
    // bit has been stable for a whole low half period
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            bit_strobe <= 1'b0;
        end else begin
            bit_strobe <= rising;
        end
    end

    // Bit counter inside the decimation window
    // It advances with every bit strobe and wraps from DECIMATION-1 to zero,
    // and the strobe at the wrap is the one that closes the window
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            dec_count  <= '0;
            dec_strobe <= 1'b0;
        end else if (rising) begin
            dec_count  <= last_bit ? '0 : dec_count + 1'b1;
            dec_strobe <= last_bit;
        end else begin
            dec_strobe <= 1'b0;
        end
    end

endmodule

/* verilog/sinc3_decimator.sv */
/*
 * Third-order sinc (CIC) decimator for one modulator bit stream.
 * Integrates the bipolar bit stream at the modulator rate and runs the
 * comb section once per decimation window, one stage per system cycle.
 */
`timescale 1ns/1ps

module sinc3_decimator (
    input  logic            clock,
    input  logic            rst_n,
    input  logic            data_in,
    input  logic            bit_strobe,
    input  logic            dec_strobe,
    output sd_pkg::sample_t data,
    output logic            valid
);

    localparam int ORDER = sd_pkg::CIC_ORDER;

    // Modulator bit mapped to plus or minus one
    sd_pkg::sample_t step;

    // Integrator registers and their values after the current bit is added
    sd_pkg::sample_t integ [ORDER];
    sd_pkg::sample_t integ_next [ORDER];

    // Comb stage delay registers, one per stage, holding the previous window
    sd_pkg::sample_t comb_dly [ORDER];

    // Comb stage result registers
    sd_pkg::sample_t comb_out [ORDER];

    // Stage enables travel down the comb one cycle per stage
    logic [ORDER-1:0] stage_en;

    // Records which comb stage holds a fresh result
    logic [ORDER-1:0] valid_pipe;

    // A one counts up and a zero counts down, so the mean is the density offset
    always_comb begin
        step = data_in ? sd_pkg::sample_t'(1) : sd_pkg::sample_t'(-1);
    end

    // Integrator chain seen through the bit about to be taken
    // Each stage adds the new value of the stage before it, so the last
    // integrator already contains the bit sampled at this strobe
    always_comb begin
        integ_next[0] = integ[0] + step;
        for (int i = 1; i < ORDER; i++) begin
            integ_next[i] = integ[i] + integ_next[i-1];
        end
    end

    // Integrators step once per modulator bit
    // Overflow wraps modulo 2^SAMPLE_W, which the comb section cancels exactly
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < ORDER; i++) begin
                integ[i] <= '0;
            end
        end else if (bit_strobe) begin
            for (int i = 0; i < ORDER; i++) begin
                integ[i] <= integ_next[i];
            end
        end
    end

    // The first stage runs on the closing bit, every later stage one cycle after the previous
    assign stage_en = {valid_pipe[ORDER-2:0], dec_strobe};

    // Comb section at the decimated rate
    // Stage zero takes the last integrator including the closing bit,
    // and every stage subtracts the value it saw one window earlier
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < ORDER; i++) begin
                comb_dly[i] <= '0;
                comb_out[i] <= '0;
            end
        end else begin
            if (stage_en[0]) begin
                comb_out[0] <= integ_next[ORDER-1] - comb_dly[0];
                comb_dly[0] <= integ_next[ORDER-1];
            end
            for (int i = 1; i < ORDER; i++) begin
                if (stage_en[i]) begin
                    comb_out[i] <= comb_out[i-1] - comb_dly[i];
                    comb_dly[i] <= comb_out[i-1];
                end
            end
        end
    end

    // Valid follows the window strobe through the comb stages
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= stage_en;
        end
    end

    // The last comb result is the sample and holds until the next window
    assign data  = comb_out[ORDER-1];
    assign valid = valid_pipe[ORDER-1];

endmodule

/* verilog/sigma_delta_processor.sv */
/*
 * Two-channel sigma-delta demodulator top level.
 * Generates the modulator clock and feeds both bit streams through
 * their own sinc3 decimator with shared bit and window strobes.
 */
`timescale 1ns/1ps

module sigma_delta_processor (
    input  logic            clock,
    input  logic            rst_n,
    input  logic [1:0]      data_in,
    output logic            clock_out,
    output sd_pkg::sample_t data_a,
    output logic            valid_a,
    output sd_pkg::sample_t data_b,
    output logic            valid_b
);

    // Strobes shared by both channels so their samples stay aligned
    logic bit_strobe;
    logic dec_strobe;

    // Modulator clock and filter timing
    sd_clock_gen u_clock_gen (
        .clock      (clock),
        .rst_n      (rst_n),
        .clock_out  (clock_out),
        .bit_strobe (bit_strobe),
        .dec_strobe (dec_strobe)
    );

    // Channel a takes bit 0 of the modulator inputs
    sinc3_decimator u_channel_a (
        .clock      (clock),
        .rst_n      (rst_n),
        .data_in    (data_in[0]),
        .bit_strobe (bit_strobe),
        .dec_strobe (dec_strobe),
        .data       (data_a),
        .valid      (valid_a)
    );

    // Channel b takes bit 1 of the modulator inputs
    sinc3_decimator u_channel_b (
        .clock      (clock),
        .rst_n      (rst_n),
        .data_in    (data_in[1]),
        .bit_strobe (bit_strobe),
        .dec_strobe (dec_strobe),
        .data       (data_b),
        .valid      (valid_b)
    );

endmodule

/* testbench/tb_sigma_delta_processor.sv */
/*
 * Testbench for the two-channel sigma-delta demodulator.
 * Replays 16-bit modulator patterns on both channels, checks the settled
 * samples against the ones density and watches clock_out and valid timing.
 */
`timescale 1ns/1ps

module tb_sigma_delta_processor;

    localparam int NUM_ROWS = 6;
    localparam int SAMPLES_PER_ROW = 5;
    // One output sample spans DECIMATION full periods of clock_out
    localparam int CYCLES_PER_SAMPLE = 2 * sd_pkg::CLOCK_DIV * sd_pkg::DECIMATION;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * SAMPLES_PER_ROW * CYCLES_PER_SAMPLE + 1000;
    localparam logic [31:0] LFSR_SEED = 32'h51ef_4e2c;
    // System cycles from the closing bit strobe to valid, one per comb stage
    localparam int VALID_DELAY = 3;

    logic            clock;
    logic            rst_n;
    logic [1:0]      data_in;
    logic            clock_out;
    sd_pkg::sample_t data_a;
    logic            valid_a;
    sd_pkg::sample_t data_b;
    logic            valid_b;

    // Stimulus table with one pattern per channel and a flag for random patterns
    // Rows are full scale, negative full scale, opposite full scale on the two
    // channels, alternating bits, twelve against four ones and then LFSR patterns
    logic [15:0] row_a [NUM_ROWS] = '{
        16'hffff, 16'h0000, 16'hffff, 16'h5555, 16'h7bde, 16'h0000
    };
    logic [15:0] row_b [NUM_ROWS] = '{
        16'hffff, 16'h0000, 16'h0000, 16'haaaa, 16'h8421, 16'h0000
    };
    logic        row_random [NUM_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

    // Patterns replayed LSB first by the bit generator
    logic [15:0] pattern_a = 16'h0000;
    logic [15:0] pattern_b = 16'h0000;
    int          bit_index = 0;
    logic        gen_prev = 1'b0;

    logic [31:0] lfsr_state = LFSR_SEED;
    int          error_count = 0;
    int          checks_done = 0;
    int          cycle_count = 0;
    logic        checks_on = 1'b0;

    // Timing monitor state
    logic        mon_prev = 1'b0;
    int          run_len = 0;
    bit          run_seen = 1'b0;
    int          rises = 0;
    int          since_rise = 0;
    logic        exp_valid = 1'b0;

    sigma_delta_processor u_sigma_delta_processor (
        .clock     (clock),
        .rst_n     (rst_n),
        .data_in   (data_in),
        .clock_out (clock_out),
        .data_a    (data_a),
        .valid_a   (valid_a),
        .data_b    (data_b),
        .valid_b   (valid_b)
    );

    always #5 clock = ~clock;

    task automatic check_sample(input string name, input sd_pkg::sample_t got,
                                input sd_pkg::sample_t exp);
        checks_done++;
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks_done++;
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
            error_count++;
        end
    endtask

    // Compares a length measured on clock_out in system cycles
    task automatic check_count(input string name, input int got, input int exp);
        checks_done++;
        if (got != exp) begin
            $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
            error_count++;
        end
    endtask

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step for every pattern bit
    task automatic random_pattern(output logic [15:0] p);
        for (int i = 0; i < 16; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            p[i] = lfsr_state[0];
        end
    endtask

    function automatic int count_ones(input logic [15:0] p);
        int k;
        k = 0;
        for (int i = 0; i < 16; i++) begin
            k += p[i];
        end
        return k;
    endfunction

    // Steady output is FULL_SCALE scaled by the bipolar density (2k - 16) / 16
    function automatic sd_pkg::sample_t expected_sample(input logic [15:0] p);
        return sd_pkg::sample_t'((sd_pkg::FULL_SCALE / 16) * (2 * count_ones(p) - 16));
    endfunction

    // Returns on a falling edge inside a valid pulse so that data is sampled while stable
    task automatic wait_valid();
        @(negedge clock);
        while (!valid_a) begin
            @(negedge clock);
        end
    endtask

    task automatic check_reset_state();
        check_bit("clock_out", clock_out, 1'b0);
        check_bit("valid_a", valid_a, 1'b0);
        check_bit("valid_b", valid_b, 1'b0);
        check_sample("data_a", data_a, '0);
        check_sample("data_b", data_b, '0);
    endtask

    // The bit generator drives a new bit after each falling edge of clock_out
    // so that data_in is stable across the next bit strobe
    always @(negedge clock) begin
        if (gen_prev && !clock_out) begin
            data_in <= {pattern_b[bit_index], pattern_a[bit_index]};
            bit_index = (bit_index + 1) % 16;
        end
        gen_prev = clock_out;
    end

    // Watches half period lengths and predicts every valid pulse from clock_out
    // The closing bit of a window is taken in the first high cycle of every
    // 128th clock_out period, and valid follows once the comb stages have run
    always @(negedge clock) begin
        if (clock_out && !mon_prev) begin
            rises++;
            since_rise = 0;
        end else begin
            since_rise++;
        end
        exp_valid = (rises > 0) && (rises % sd_pkg::DECIMATION == 0)
                    && (since_rise == VALID_DELAY);
        if (checks_on) begin
            if (clock_out == mon_prev) begin
                run_len++;
            end else begin
                if (run_seen) begin
                    check_count("clock_out half period", run_len, sd_pkg::CLOCK_DIV);
                end
                run_seen = 1'b1;
                run_len = 1;
            end
            check_bit("valid_a", valid_a, exp_valid);
            check_bit("valid_b", valid_b, exp_valid);
        end
        mon_prev = clock_out;
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the test rows did not complete", cycle_count);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        logic [15:0] pa;
        logic [15:0] pb;
        sd_pkg::sample_t exp_a;
        sd_pkg::sample_t exp_b;
        clock = 1'b0;
        rst_n = 1'b0;
        data_in = 2'b00;
        // Reset held over three rising edges, then the first cycle after it
        repeat (3) begin
            @(negedge clock);
            check_reset_state();
        end
        rst_n <= 1'b1;
        @(negedge clock);
        check_reset_state();
        checks_on <= 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (row_random[r]) begin
                random_pattern(pa);
                random_pattern(pb);
            end else begin
                pa = row_a[r];
                pb = row_b[r];
            end
            pattern_a <= pa;
            pattern_b <= pb;
            exp_a = expected_sample(pa);
            exp_b = expected_sample(pb);
            // The first three samples still see the previous row
            repeat (3) wait_valid();
            repeat (2) begin
                wait_valid();
                check_sample("data_a", data_a, exp_a);
                check_sample("data_b", data_b, exp_b);
            end
        end
        $display("%0d checks, %0d errors", checks_done, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* sigma_delta_processor.f */
verilog/sd_pkg.sv
verilog/sd_clock_gen.sv
verilog/sinc3_decimator.sv
verilog/sigma_delta_processor.sv
testbench/tb_sigma_delta_processor.sv

/* Bender.yml */
package:
  name: sigma_delta_processor

sources:
  - verilog/sd_pkg.sv
  - verilog/sd_clock_gen.sv
  - verilog/sinc3_decimator.sv
  - verilog/sigma_delta_processor.sv
  - target: test
    files:
      - testbench/tb_sigma_delta_processor.sv
